// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_uart_controller
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation finished: PASS

.PHONY: sim clean

# build, run, then decide on the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
uart_pkg.sv
uart_baud_gen.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_controller.sv
uart_checker.sv
tb_uart_controller.sv

// ==== tb_uart_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_uart_controller;
    import uart_pkg::*;

    // clocks per serial bit, and the longest any wait may take
    localparam int BIT_CYCLES = BAUD_DIV * OVERSAMPLE;
    localparam int TIMEOUT    = 20 * BIT_CYCLES;

    logic         clk;
    logic         reset;
    tx_req_t      tx_req;
    logic         tx_ready;
    rx_rsp_t      rx_rsp;
    logic         rx_ready;
    logic         rx_line;
    logic         tx_line;
    uart_status_t status;

    // serial input source, driven or looped back from tx_line
    logic loopback;
    logic rx_drive;

    int seed            = 32'h1c84_16d9;
    int error_count     = 0;
    int tests_passed    = 0;
    int tests_failed    = 0;
    int tx_stall_cycles = 0;

    assign rx_line = loopback ? tx_line : rx_drive;

    uart_controller UUT (
        .clk      (clk),
        .reset    (reset),
        .tx_req   (tx_req),
        .tx_ready (tx_ready),
        .rx_rsp   (rx_rsp),
        .rx_ready (rx_ready),
        .rx_line  (rx_line),
        .tx_line  (tx_line),
        .status   (status)
    );

    // protocol assertions inside the controller
    bind uart_controller uart_checker checker_inst (
        .clk           (clk),
        .reset         (reset),
        .tx_line       (tx_line),
        .tx_ready      (tx_ready),
        .tx_fifo_valid (tx_fifo_valid),
        .rx_rsp        (rx_rsp),
        .rx_ready      (rx_ready),
        .status        (status)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // cycles with the tx fifo full
    always @(negedge clk) begin
        if (!reset && !tx_ready) begin
            tx_stall_cycles = tx_stall_cycles + 1;
        end
    end

    //////////////////////////////
    // helpers and compare tasks
    //////////////////////////////

    function automatic uart_byte_t next_random_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic apply_reset();
        reset = 1'b1;
        repeat (8) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic report_error(input string name, input string what);
        $display("ERROR %s: %s", name, what);
        error_count++;
    endtask

    task automatic compare_byte(input string name, input uart_byte_t expected,
                                input uart_byte_t actual);
        if (expected !== actual) begin
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_frame(input string name, input rx_frame_t expected,
                                 input rx_frame_t actual);
        if (expected !== actual) begin
            $display("MISMATCH %s: expected data %h err %b, actual data %h err %b", name,
                     expected.data, expected.frame_err, actual.data, actual.frame_err);
            error_count++;
        end
    endtask

    task automatic compare_status(input string name, input uart_status_t expected,
                                  input uart_status_t actual);
        if (expected !== actual) begin
            $display("MISMATCH %s: expected ovr/rxb/txb %b, actual %b", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed, %0d errors", name, error_count - errs_before);
        end
    endtask

    //////////////////////////////
    // serial and host side
    //////////////////////////////

    // start, 8 data lsb first, stop, then one idle bit
    task automatic send_serial(input uart_byte_t value, input logic stop);
        rx_drive = 1'b0;
        repeat (BIT_CYCLES) @(negedge clk);
        for (int i = 0; i < DATA_BITS; i++) begin
            rx_drive = value[i];
            repeat (BIT_CYCLES) @(negedge clk);
        end
        rx_drive = stop;
        repeat (BIT_CYCLES) @(negedge clk);
        // idle high so a low stop still gives a clean next start edge
        rx_drive = 1'b1;
        repeat (BIT_CYCLES) @(negedge clk);
    endtask

    // returns at the middle of the stop bit
    task automatic capture_serial(input string name, output uart_byte_t value,
                                  output logic stop);
        int cnt;
        cnt   = 0;
        value = '0;
        stop  = 1'b0;
        while (tx_line !== 1'b0 && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (tx_line !== 1'b0) begin
            report_error(name, "no start bit on tx_line before the timeout");
        end else begin
            repeat (BIT_CYCLES / 2) @(negedge clk);
            if (tx_line !== 1'b0) begin
                report_error(name, "start bit did not last to its middle");
            end
            for (int i = 0; i < DATA_BITS; i++) begin
                repeat (BIT_CYCLES) @(negedge clk);
                value[i] = tx_line;
            end
            repeat (BIT_CYCLES) @(negedge clk);
            stop = tx_line;
        end
    endtask

    // called on a falling edge, ready sampled there
    task automatic host_write(input string name, input uart_byte_t value);
        int cnt;
        cnt    = 0;
        tx_req = '{valid: 1'b1, data: value};
        while (!tx_ready && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!tx_ready) begin
            report_error(name, "tx_ready stayed low, byte was not accepted");
        end
        @(negedge clk);
        tx_req.valid = 1'b0;
    endtask

    task automatic host_read(input string name, output rx_frame_t frame);
        int cnt;
        cnt   = 0;
        frame = '0;
        while (!rx_rsp.valid && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!rx_rsp.valid) begin
            report_error(name, "no frame became valid on the read channel");
        end else begin
            frame    = rx_rsp.frame;
            rx_ready = 1'b1;
            @(negedge clk);
            rx_ready = 1'b0;
        end
    endtask

    task automatic wait_tx_idle(input string name);
        int cnt;
        cnt = 0;
        while (status.tx_busy && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (status.tx_busy) begin
            report_error(name, "transmitter never returned to idle");
        end
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic test_tx_framing();
        int           errs;
        uart_byte_t   got;
        logic         stop;
        uart_status_t expected_status;
        errs = error_count;
        host_write("tx_framing", 8'hA5);
        capture_serial("tx_framing", got, stop);
        compare_byte("tx_framing data", 8'hA5, got);
        compare_bit("tx_framing stop", 1'b1, stop);
        // still inside the stop bit
        expected_status = '{rx_overrun: 1'b0, rx_busy: 1'b0, tx_busy: 1'b1};
        compare_status("tx_framing busy", expected_status, status);
        wait_tx_idle("tx_framing");
        compare_bit("tx_framing idle line", 1'b1, tx_line);
        report_test("tx_framing", errs);
    endtask

    // good stop and low stop share the same steps
    task automatic test_rx_frame(input string name, input uart_byte_t value, input logic stop);
        int           errs;
        rx_frame_t    got;
        rx_frame_t    expected;
        uart_status_t busy_status;
        errs        = error_count;
        expected    = '{data: value, frame_err: !stop};
        busy_status = '{rx_overrun: 1'b0, rx_busy: 1'b1, tx_busy: 1'b0};
        fork
            send_serial(value, stop);
            begin
                // well inside the data bits
                repeat (5 * BIT_CYCLES) @(negedge clk);
                compare_status({name, " busy"}, busy_status, status);
            end
        join
        host_read(name, got);
        compare_frame(name, expected, got);
        report_test(name, errs);
    endtask

    task automatic test_tx_backpressure();
        int         errs;
        int         stall_start;
        uart_byte_t expected_q[$];
        uart_byte_t b;
        uart_byte_t got;
        logic       stop;
        errs        = error_count;
        stall_start = tx_stall_cycles;
        fork
            begin
                for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
                    b = next_random_byte();
                    expected_q.push_back(b);
                    host_write("tx_backpressure", b);
                end
            end
            begin
                for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
                    capture_serial("tx_backpressure", got, stop);
                    if (expected_q.size() == 0) begin
                        report_error("tx_backpressure", "byte on tx_line that was never written");
                    end else begin
                        compare_byte("tx_backpressure data", expected_q.pop_front(), got);
                    end
                    compare_bit("tx_backpressure stop", 1'b1, stop);
                end
            end
        join
        if (tx_stall_cycles == stall_start) begin
            report_error("tx_backpressure", "tx_ready was never seen low");
        end
        wait_tx_idle("tx_backpressure");
        report_test("tx_backpressure", errs);
    endtask

    task automatic test_rx_overflow();
        int           errs;
        uart_byte_t   expected_q[$];
        uart_byte_t   b;
        rx_frame_t    got;
        uart_status_t expected_status;
        errs = error_count;
        // the last two frames find the fifo full
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            b = next_random_byte();
            if (i < FIFO_DEPTH) begin
                expected_q.push_back(b);
            end
            send_serial(b, 1'b1);
        end
        expected_status = '{rx_overrun: 1'b1, rx_busy: 1'b0, tx_busy: 1'b0};
        compare_status("rx_overflow status", expected_status, status);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            host_read("rx_overflow", got);
            compare_frame("rx_overflow frame", '{data: expected_q.pop_front(), frame_err: 1'b0},
                          got);
        end
        // nothing behind the first FIFO_DEPTH frames
        for (int i = 0; i < BIT_CYCLES; i++) begin
            @(negedge clk);
            if (rx_rsp.valid) begin
                report_error("rx_overflow", "read channel valid after the fifo drained");
                break;
            end
        end
        report_test("rx_overflow", errs);
    endtask

    task automatic test_loopback();
        int         errs;
        uart_byte_t expected_q[$];
        uart_byte_t b;
        rx_frame_t  got;
        errs     = error_count;
        loopback = 1'b1;
        fork
            begin
                for (int i = 0; i < 12; i++) begin
                    b = next_random_byte();
                    expected_q.push_back(b);
                    host_write("loopback", b);
                end
            end
            begin
                for (int i = 0; i < 12; i++) begin
                    host_read("loopback", got);
                    compare_frame("loopback frame", '{data: expected_q.pop_front(), frame_err: 1'b0},
                                  got);
                end
            end
        join
        wait_tx_idle("loopback");
        loopback = 1'b0;
        report_test("loopback", errs);
    endtask

    initial begin
        reset    = 1'b1;
        tx_req   = '0;
        rx_ready = 1'b0;
        rx_drive = 1'b1;
        loopback = 1'b0;
        apply_reset();
        test_tx_framing();
        test_rx_frame("rx_path", 8'h3C, 1'b1);
        test_rx_frame("framing_error", 8'h81, 1'b0);
        test_tx_backpressure();
        test_rx_overflow();
        // overrun is sticky, clear it for the stream
        apply_reset();
        test_loopback();
        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== uart_baud_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_baud_gen (
    input  logic clk,
    input  logic reset,
    output logic tick
);
    import uart_pkg::*;

    // clocks since last tick
    logic [BAUD_CNT_W-1:0] div_cnt;
    // last count of the period
    logic                  wrap;

    assign wrap = (div_cnt == BAUD_CNT_W'(BAUD_DIV - 1));

    // free running divider
    // restarts at zero on reset so tick phase is known
    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= '0;
        end else if (wrap) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // one cycle wide, once per BAUD_DIV clocks
    assign tick = wrap;

endmodule

`default_nettype wire

// ==== uart_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_checker (
    input logic                   clk,
    input logic                   reset,
    input logic                   tx_line,
    input logic                   tx_ready,
    input logic                   tx_fifo_valid,
    input uart_pkg::rx_rsp_t      rx_rsp,
    input logic                   rx_ready,
    input uart_pkg::uart_status_t status
);

    // reset on the previous edge, line is defined after the first reset clock
    logic reset_d = 1'b0;

    always @(posedge clk) begin
        reset_d <= reset;
    end

    //////////////////////////////
    // line and host channels
    //////////////////////////////

    // idle line while held in reset
    tx_idle_in_reset: assert property (@(posedge clk) reset && reset_d |-> tx_line)
        else $error("tx_line low while reset is active");

    // read channel holds its frame until taken
    rx_rsp_stable: assert property (@(posedge clk) disable iff (reset)
        rx_rsp.valid && !rx_ready |=> $stable(rx_rsp))
        else $error("rx_rsp changed while valid and not ready");

    // sticky until the next reset
    overrun_sticky: assert property (@(posedge clk) disable iff (reset)
        status.rx_overrun |=> status.rx_overrun)
        else $error("rx_overrun cleared without reset");

    // empty tx fifo always has room
    tx_ready_when_empty: assert property (@(posedge clk) disable iff (reset)
        !tx_fifo_valid |-> tx_ready)
        else $error("tx_ready low with the transmit fifo empty");

endmodule

`default_nettype wire

// ==== uart_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_controller (
    input  logic                   clk,
    input  logic                   reset,
    input  uart_pkg::tx_req_t      tx_req,
    output logic                   tx_ready,
    output uart_pkg::rx_rsp_t      rx_rsp,
    input  logic                   rx_ready,
    input  logic                   rx_line,
    output logic                   tx_line,
    output uart_pkg::uart_status_t status
);
    import uart_pkg::*;

    // shared 16x tick
    logic tick;

    // tx fifo to serializer
    logic       tx_fifo_valid;
    logic       tx_fifo_ready;
    uart_byte_t tx_fifo_data;

    // receiver to rx fifo
    logic      rx_push_valid;
    logic      rx_push_ready;
    rx_frame_t rx_push_frame;

    // rx fifo head to host
    logic      rx_head_valid;
    rx_frame_t rx_head_frame;

    // engine flags
    logic tx_busy;
    logic rx_busy;
    logic rx_overrun;

    //////////////////////////////
    // baud tick
    //////////////////////////////

    uart_baud_gen baud_gen (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    //////////////////////////////
    // transmit path
    //////////////////////////////

    // tx_ready is the fifo not-full flag
    uart_fifo #(
        .payload_t (uart_byte_t),
        .DEPTH     (FIFO_DEPTH)
    ) tx_fifo (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (tx_req.valid),
        .in_data   (tx_req.data),
        .in_ready  (tx_ready),
        .out_valid (tx_fifo_valid),
        .out_data  (tx_fifo_data),
        .out_ready (tx_fifo_ready)
    );

    // pops only while idle
    uart_tx tx_engine (
        .clk      (clk),
        .reset    (reset),
        .tick     (tick),
        .in_valid (tx_fifo_valid),
        .in_data  (tx_fifo_data),
        .in_ready (tx_fifo_ready),
        .line     (tx_line),
        .busy     (tx_busy)
    );

    //////////////////////////////
    // receive path
    //////////////////////////////

    // drops the frame when the fifo is full
    uart_rx rx_engine (
        .clk       (clk),
        .reset     (reset),
        .tick      (tick),
        .line      (rx_line),
        .out_ready (rx_push_ready),
        .out_valid (rx_push_valid),
        .out_frame (rx_push_frame),
        .busy      (rx_busy),
        .overrun   (rx_overrun)
    );

    uart_fifo #(
        .payload_t (rx_frame_t),
        .DEPTH     (FIFO_DEPTH)
    ) rx_fifo (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (rx_push_valid),
        .in_data   (rx_push_frame),
        .in_ready  (rx_push_ready),
        .out_valid (rx_head_valid),
        .out_data  (rx_head_frame),
        .out_ready (rx_ready)
    );

    // host side structs
    assign rx_rsp = '{valid: rx_head_valid, frame: rx_head_frame};
    assign status = '{rx_overrun: rx_overrun, rx_busy: rx_busy, tx_busy: tx_busy};

endmodule

`default_nettype wire

// ==== uart_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);
    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

    payload_t mem [DEPTH];
    ptr_t     wr_ptr;
    ptr_t     rd_ptr;
    cnt_t     count;
    logic     full;
    logic     empty;
    logic     push;
    logic     pop;

    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign in_ready  = !full;
    assign out_valid = !empty;
    // head entry shown with valid, first word fall through
    assign out_data  = mem[rd_ptr];

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // pointers wrap at DEPTH, any depth works
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // flags registered with the count
            case ({push, pop})
                2'b10: begin
                    count <= count + 1'b1;
                    empty <= 1'b0;
                    full  <= (count == cnt_t'(DEPTH - 1));
                end
                2'b01: begin
                    count <= count - 1'b1;
                    full  <= 1'b0;
                    empty <= (count == cnt_t'(1));
                end
                // both or neither, occupancy unchanged
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    //////////////////////////////
    // frame and timing constants
    //////////////////////////////

    // data bits per frame, sent lsb first
    localparam int DATA_BITS  = 8;
    // ticks per bit period
    localparam int OVERSAMPLE = 16;
    // clocks per 16x tick, so one bit is 64 clocks
    localparam int BAUD_DIV   = 4;
    // entries in each fifo
    localparam int FIFO_DEPTH = 8;

    // counter widths derived from the above
    localparam int BAUD_CNT_W = $clog2(BAUD_DIV);
    localparam int TICK_CNT_W = $clog2(OVERSAMPLE);
    localparam int BIT_CNT_W  = $clog2(DATA_BITS);

    //////////////////////////////
    // payloads and host channels
    //////////////////////////////

    typedef logic [DATA_BITS-1:0] uart_byte_t;

    // one received frame, 9 bits
    typedef struct packed {
        uart_byte_t data;
        logic       frame_err;  // stop bit sampled low
    } rx_frame_t;

    // host write channel, ready comes back separately
    typedef struct packed {
        logic       valid;
        uart_byte_t data;
    } tx_req_t;

    // host read channel
    typedef struct packed {
        logic      valid;
        rx_frame_t frame;
    } rx_rsp_t;

    // overrun is sticky, the busy flags are live
    typedef struct packed {
        logic rx_overrun;
        logic rx_busy;
        logic tx_busy;
    } uart_status_t;

endpackage

`default_nettype wire

// ==== uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic                clk,
    input  logic                reset,
    input  logic                tick,
    input  logic                line,
    input  logic                out_ready,
    output logic                out_valid,
    output uart_pkg::rx_frame_t out_frame,
    output logic                busy,
    output logic                overrun
);
    import uart_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t             state;
    logic [TICK_CNT_W-1:0] tick_cnt;
    logic [BIT_CNT_W-1:0]  bit_idx;
    uart_byte_t            shift_reg;

    // two sync flops plus one more for edge detect
    logic [2:0] line_sync;
    logic       line_s;
    logic       line_fall;

    // sample points
    logic half_point;
    logic full_point;

    assign line_s     = line_sync[1];
    assign line_fall  = line_sync[2] && !line_sync[1];
    assign half_point = tick && (tick_cnt == TICK_CNT_W'(OVERSAMPLE / 2 - 1));
    assign full_point = tick && (tick_cnt == TICK_CNT_W'(OVERSAMPLE - 1));
    assign busy       = (state != RX_IDLE);

    //////////////////////////////
    // input synchronizer
    //////////////////////////////

    // resets to idle high, no false start out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            line_sync <= '1;
        end else begin
            line_sync <= {line_sync[1:0], line};
        end
    end

    //////////////////////////////
    // receive fsm
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= RX_IDLE;
            tick_cnt  <= '0;
            bit_idx   <= '0;
            out_valid <= 1'b0;
            overrun   <= 1'b0;
        end else begin
            // frame handed to fifo
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    if (line_fall) begin
                        state <= RX_START;
                    end
                end
                // wait to mid start bit, then recheck
                RX_START: begin
                    if (half_point) begin
                        tick_cnt <= '0;
                        bit_idx  <= '0;
                        // high again means a glitch
                        state    <= line_s ? RX_IDLE : RX_DATA;
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                    if (full_point) begin
                        tick_cnt <= '0;
                        if (bit_idx == BIT_CNT_W'(DATA_BITS - 1)) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                RX_STOP: begin
                    if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                    // frame complete at mid stop bit
                    if (full_point) begin
                        tick_cnt  <= '0;
                        state     <= RX_IDLE;
                        out_valid <= out_ready;
                        // fifo full, drop it, flag stays until reset
                        if (!out_ready) begin
                            overrun <= 1'b1;
                        end
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // data path, lsb arrives first so shift in from the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA && full_point) begin
            shift_reg <= {line_s, shift_reg[DATA_BITS-1:1]};
        end
        if (state == RX_STOP && full_point) begin
            out_frame <= '{data: shift_reg, frame_err: !line_s};
        end
    end

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 tick,
    input  logic                 in_valid,
    input  uart_pkg::uart_byte_t in_data,
    output logic                 in_ready,
    output logic                 line,
    output logic                 busy
);
    import uart_pkg::*;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    tx_state_t             state;
    logic [TICK_CNT_W-1:0] tick_cnt;
    logic [BIT_CNT_W-1:0]  bit_idx;
    uart_byte_t            shift_reg;

    // line changes only on bit_start, so every bit is exactly 16 ticks
    logic bit_start;
    logic bit_end;

    assign bit_start = tick && (tick_cnt == '0);
    assign bit_end   = tick && (tick_cnt == TICK_CNT_W'(OVERSAMPLE - 1));
    assign in_ready  = (state == TX_IDLE);
    assign busy      = (state != TX_IDLE);

    // ticks within the current bit
    always_ff @(posedge clk) begin
        if (reset) begin
            tick_cnt <= '0;
        end else if (state == TX_IDLE || bit_end) begin
            tick_cnt <= '0;
        end else if (tick) begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= TX_IDLE;
            bit_idx <= '0;
            line    <= 1'b1;
        end else begin
            case (state)
                // byte accepted here, start bit falls on next tick
                TX_IDLE: begin
                    if (in_valid) begin
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_start) begin
                        line <= 1'b0;
                    end
                    if (bit_end) begin
                        bit_idx <= '0;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_start) begin
                        line <= shift_reg[0];
                    end
                    if (bit_end) begin
                        if (bit_idx == BIT_CNT_W'(DATA_BITS - 1)) begin
                            state <= TX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                // back through idle for one cycle, next start still lands on a tick
                TX_STOP: begin
                    if (bit_start) begin
                        line <= 1'b1;
                    end
                    if (bit_end) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // shift register, lsb goes out first
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            shift_reg <= in_data;
        end else if (state == TX_DATA && bit_end) begin
            shift_reg <= {1'b0, shift_reg[DATA_BITS-1:1]};
        end
    end

endmodule

`default_nettype wire
